// File: Bender.yml
package:
  name: hazard_detect

sources:
  # design sources, package first
  - files:
      - hdl/hazardPkg.sv
      - hdl/instrDecoder.sv
      - hdl/writeTracker.sv
      - hdl/memTracker.sv
      - hdl/hazardDetect.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - sim/hazardDetect_props.sv
      - sim/tb_hazardDetect.sv

// File: all.f
hdl/hazardPkg.sv
hdl/instrDecoder.sv
hdl/writeTracker.sv
hdl/memTracker.sv
hdl/hazardDetect.sv
sim/hazardDetect_props.sv
sim/tb_hazardDetect.sv

// File: hdl/hazardDetect.sv
`timescale 1ns/1ps
`default_nettype none

// Issue-side hazard detection for the five-stage pipeline. It decodes the
// offered instruction, checks it against the register and memory histories,
// and tells the front end whether to stall or to squash a slot.
module hazardDetect (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire                    instrValid,
    input  wire hazardPkg::instrT  instr,
    input  wire hazardPkg::addrT   rsValue,
    input  wire hazardPkg::addrT   imm,
    output logic                   nop,
    output logic                   pcStall,
    output logic                   branchBubble
);

    hazardPkg::regIdxT rs;
    hazardPkg::regIdxT rt;
    hazardPkg::regIdxT rd;
    hazardPkg::addrT   memAddr;

    logic writesReg;
    logic isMem;
    logic isControl;
    logic regHazard;
    logic memHazard;
    logic hazard;
    logic issue;

    // ======================================================================
    // decode and hazard trackers
    // ======================================================================

    // the class itself is only needed inside the decoder.
    instrDecoder instrDecoder_inst (
        .instr      (instr),
        .rsValue    (rsValue),
        .imm        (imm),
        .rs         (rs),
        .rt         (rt),
        .rd         (rd),
        .instrClass (),
        .writesReg  (writesReg),
        .isMem      (isMem),
        .isControl  (isControl),
        .memAddr    (memAddr)
    );

    writeTracker writeTracker_inst (
        .clk       (clk),
        .rstN      (rstN),
        .issue     (issue),
        .writesReg (writesReg),
        .rd        (rd),
        .rs        (rs),
        .rt        (rt),
        .regHazard (regHazard)
    );

    memTracker memTracker_inst (
        .clk       (clk),
        .rstN      (rstN),
        .issue     (issue),
        .isMem     (isMem),
        .memAddr   (memAddr),
        .memHazard (memHazard)
    );

    // ======================================================================
    // stall and issue
    // ======================================================================

    // the fields of an empty slot are don't-care, so both hazards are gated.
    assign hazard  = instrValid & (regHazard | memHazard);
    assign nop     = hazard;
    assign pcStall = hazard;

    // issue feeds back into both histories on the next edge.
    assign issue        = instrValid & ~hazard;
    assign branchBubble = issue & isControl;

endmodule

`default_nettype wire

// File: hdl/hazardPkg.sv
`default_nettype none

package hazardPkg;

    // ======================================================================
    // word and field widths
    // ======================================================================

    // one fetched instruction. opcode in 15..11, rs in 10..8, rt in 7..5
    // and rd in 4..2.
    typedef logic [15:0] instrT;

    // index into the eight-entry register file.
    typedef logic [2:0] regIdxT;

    // data memory address. rsValue and the immediate share this width.
    typedef logic [15:0] addrT;

    // major opcode field of an instruction.
    typedef logic [4:0] opcodeT;

    // ======================================================================
    // pipeline depth and opcode map
    // ======================================================================

    // stages tracked behind IF, ordered ID, EX, MEM, WB.
    localparam int NUM_STAGES = 4;

    // the only two opcodes that touch data memory.
    localparam opcodeT OPC_LOAD = 5'b10000;
    localparam opcodeT OPC_STORE = 5'b10001;

    // class prefixes, matched against the upper opcode bits.
    localparam logic [1:0] PFX_ALU = 2'b00;
    localparam logic [2:0] PFX_ALU_IMM = 3'b010;
    localparam logic [2:0] PFX_BRANCH = 3'b011;

    // the remaining 10xxx opcodes are treated as no-ops here.
    localparam logic [1:0] PFX_MEM = 2'b10;
    localparam logic [2:0] PFX_SET = 3'b110;
    localparam logic [2:0] PFX_JUMP = 3'b111;

    // ======================================================================
    // decode classes
    // ======================================================================

    // ALU also covers immediate ALU and set-type, since all three write rd.
    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JUMP
    } instrClassE;

endpackage

`default_nettype wire

// File: hdl/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

// Decodes the instruction offered by the front end. Everything here is
// combinational, so the hazard compare sees the fields in the same cycle.
module instrDecoder (
    input  wire hazardPkg::instrT    instr,
    input  wire hazardPkg::addrT     rsValue,
    input  wire hazardPkg::addrT     imm,
    output hazardPkg::regIdxT        rs,
    output hazardPkg::regIdxT        rt,
    output hazardPkg::regIdxT        rd,
    output hazardPkg::instrClassE    instrClass,
    output logic                     writesReg,
    output logic                     isMem,
    output logic                     isControl,
    output hazardPkg::addrT          memAddr
);

    hazardPkg::opcodeT opcode;

    // ======================================================================
    // field extraction
    // ======================================================================

    assign opcode = instr[15:11];
    assign rs     = instr[10:8];
    assign rt     = instr[7:5];
    assign rd     = instr[4:2];

    // ======================================================================
    // opcode classification
    // ======================================================================

    // the exact load and store opcodes come first, so they win over the
    // wider 10xxx memory prefix that follows them.
    always_comb begin
        case (opcode) inside
            hazardPkg::OPC_LOAD: begin
                instrClass = hazardPkg::CLS_LOAD;
            end
            hazardPkg::OPC_STORE: begin
                instrClass = hazardPkg::CLS_STORE;
            end
            {hazardPkg::PFX_MEM, 3'b???}: begin
                instrClass = hazardPkg::CLS_NONE;
            end
            {hazardPkg::PFX_ALU, 3'b???}: begin
                instrClass = hazardPkg::CLS_ALU;
            end
            {hazardPkg::PFX_ALU_IMM, 2'b??}: begin
                instrClass = hazardPkg::CLS_ALU;
            end
            {hazardPkg::PFX_SET, 2'b??}: begin
                instrClass = hazardPkg::CLS_ALU;
            end
            {hazardPkg::PFX_BRANCH, 2'b??}: begin
                instrClass = hazardPkg::CLS_BRANCH;
            end
            {hazardPkg::PFX_JUMP, 2'b??}: begin
                instrClass = hazardPkg::CLS_JUMP;
            end
            default: begin
                instrClass = hazardPkg::CLS_NONE;
            end
        endcase
    end

    // ======================================================================
    // class flags and address
    // ======================================================================

    // only ALU-type results and loads come back to the register file.
    assign writesReg = (instrClass == hazardPkg::CLS_ALU) ||
                       (instrClass == hazardPkg::CLS_LOAD);

    assign isMem = (instrClass == hazardPkg::CLS_LOAD) ||
                   (instrClass == hazardPkg::CLS_STORE);

    // branches and jumps both redirect fetch, so the next slot gets squashed.
    assign isControl = (instrClass == hazardPkg::CLS_BRANCH) ||
                       (instrClass == hazardPkg::CLS_JUMP);

    // effective address wraps at 16 bits, the carry out is not kept.
    assign memAddr = rsValue + imm;

endmodule

`default_nettype wire

// File: hdl/memTracker.sv
`timescale 1ns/1ps
`default_nettype none

// Keeps the effective address of every memory instruction in flight and
// stops a new memory access to the same address until the older one drains.
module memTracker (
    input  wire                   clk,
    input  wire                   rstN,
    input  wire                   issue,
    input  wire                   isMem,
    input  wire hazardPkg::addrT  memAddr,
    output logic                  memHazard
);

    // index 0 is ID, index NUM_STAGES-1 is WB.
    hazardPkg::addrT addrHist [hazardPkg::NUM_STAGES];
    logic            validHist [hazardPkg::NUM_STAGES];

    logic [hazardPkg::NUM_STAGES-1:0] addrMatch;

    // ======================================================================
    // history shift
    // ======================================================================

    // same shift discipline as the register history. Only an issued load or
    // store leaves a valid entry behind.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < hazardPkg::NUM_STAGES; i++) begin
                validHist[i] <= 1'b0;
            end
        end else begin
            validHist[0] <= issue & isMem;
            for (int i = 1; i < hazardPkg::NUM_STAGES; i++) begin
                validHist[i] <= validHist[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        addrHist[0] <= memAddr;
        for (int i = 1; i < hazardPkg::NUM_STAGES; i++) begin
            addrHist[i] <= addrHist[i-1];
        end
    end

    // ======================================================================
    // address conflict compare
    // ======================================================================

    // one compare per stage, kept as a vector so the stage that matched is
    // easy to spot in a waveform.
    always_comb begin
        for (int i = 0; i < hazardPkg::NUM_STAGES; i++) begin
            addrMatch[i] = validHist[i] && (addrHist[i] == memAddr);
        end
    end

    // a non-memory instruction never conflicts, whatever its rsValue and
    // immediate happen to add up to.
    assign memHazard = isMem & (|addrMatch);

    // Loads are tracked as well as stores. That is stricter than needed for
    // two loads, but it keeps the rule symmetric.

endmodule

`default_nettype wire

// File: hdl/writeTracker.sv
`timescale 1ns/1ps
`default_nettype none

// Keeps the destination register of every instruction still in flight
// behind IF and flags a read-after-write conflict for the offered one.
module writeTracker (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire                     issue,
    input  wire                     writesReg,
    input  wire hazardPkg::regIdxT  rd,
    input  wire hazardPkg::regIdxT  rs,
    input  wire hazardPkg::regIdxT  rt,
    output logic                    regHazard
);

    // index 0 is ID, index NUM_STAGES-1 is WB.
    hazardPkg::regIdxT rdHist [hazardPkg::NUM_STAGES];
    logic              validHist [hazardPkg::NUM_STAGES];

    // ======================================================================
    // history shift
    // ======================================================================

    // a stalled or idle cycle loads an invalid entry, which is the bubble
    // that walks down the pipe in place of the held instruction.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < hazardPkg::NUM_STAGES; i++) begin
                validHist[i] <= 1'b0;
            end
        end else begin
            validHist[0] <= issue & writesReg;
            for (int i = 1; i < hazardPkg::NUM_STAGES; i++) begin
                validHist[i] <= validHist[i-1];
            end
        end
    end

    // the register index only matters while its valid bit is set.
    always_ff @(posedge clk) begin
        rdHist[0] <= rd;
        for (int i = 1; i < hazardPkg::NUM_STAGES; i++) begin
            rdHist[i] <= rdHist[i-1];
        end
    end

    // ======================================================================
    // read-after-write compare
    // ======================================================================

    // both source fields are checked for every class. A class that does not
    // read rt may stall needlessly, which costs cycles but never correctness.
    always_comb begin
        logic anyMatch;

        anyMatch = 1'b0;
        for (int i = 0; i < hazardPkg::NUM_STAGES; i++) begin
            if (validHist[i] && (rdHist[i] == rs)) begin
                anyMatch = 1'b1;
            end
            if (validHist[i] && (rdHist[i] == rt)) begin
                anyMatch = 1'b1;
            end
        end
        regHazard = anyMatch;
    end

    // WB still counts as a hazard. The register file is not written through,
    // so a read in the same cycle as the write would return the old value.

endmodule

`default_nettype wire

// File: sim/hazardDetect_props.sv
`timescale 1ns/1ps
`default_nettype none

module hazardDetectProps (
    input wire                   clk,
    input wire                   rstN,
    input wire                   instrValid,
    input wire hazardPkg::instrT instr,
    input wire                   nop,
    input wire                   pcStall,
    input wire                   branchBubble
);

    int failCount = 0;

    // ======================================================================
    // output consistency
    // ======================================================================

    nopMatchesStall: assert property (@(posedge clk) disable iff (!rstN)
        nop == pcStall)
        else begin
            failCount++;
            $error("nop and pcStall differ");
        end

    // a stalled slot does not issue, so it cannot squash the next one.
    noBubbleWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
        !(branchBubble && pcStall))
        else begin
            failCount++;
            $error("branchBubble high during a stall");
        end

    quietWhenEmpty: assert property (@(posedge clk) disable iff (!rstN)
        !instrValid |-> !(nop || pcStall || branchBubble))
        else begin
            failCount++;
            $error("output high with instrValid low");
        end

    // ======================================================================
    // stall length
    // ======================================================================

    // bubbles drain one stage per cycle, so four stalled cycles are the limit.
    stallEnds: assert property (@(posedge clk) disable iff (!rstN)
        (pcStall && $past(pcStall) && $past(pcStall, 2) && $past(pcStall, 3))
        |=> !pcStall)
        else begin
            failCount++;
            $error("stall lasted more than four cycles");
        end

    instrHeld: assert property (@(posedge clk) disable iff (!rstN)
        pcStall |=> $stable(instr))
        else begin
            failCount++;
            $error("instr changed during a stall");
        end

endmodule

bind hazardDetect hazardDetectProps hazardDetectProps_inst (
    .clk          (clk),
    .rstN         (rstN),
    .instrValid   (instrValid),
    .instr        (instr),
    .nop          (nop),
    .pcStall      (pcStall),
    .branchBubble (branchBubble)
);

`default_nettype wire

// File: sim/tb_hazardDetect.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hazardDetect;

    localparam int STALL_TIMEOUT = 8;
    localparam int RESET_TIMEOUT = 10;
    localparam int RANDOM_COUNT = 300;

    localparam hazardPkg::opcodeT OPC_ALU = 5'b00001;
    localparam hazardPkg::opcodeT OPC_BRANCH = 5'b01100;
    localparam hazardPkg::opcodeT OPC_JUMP = 5'b11100;

    logic               clk;
    logic               rstN;
    logic               instrValid;
    hazardPkg::instrT   instr;
    hazardPkg::addrT    rsValue;
    hazardPkg::addrT    imm;
    logic               nop;
    logic               pcStall;
    logic               branchBubble;

    // model of the tracked stages, index 0 is ID and the last one is WB.
    hazardPkg::regIdxT [hazardPkg::NUM_STAGES-1:0] rdModel;
    logic [hazardPkg::NUM_STAGES-1:0]              rdValidModel;
    hazardPkg::addrT [hazardPkg::NUM_STAGES-1:0]   addrModel;
    logic [hazardPkg::NUM_STAGES-1:0]              addrValidModel;

    int               errorCount = 0;
    int               checkCount = 0;
    int               testStartErrors = 0;
    logic             stallSeen = 1'b0;
    hazardPkg::instrT heldInstr;

    hazardDetect hazardDetect_inst (
        .clk          (clk),
        .rstN         (rstN),
        .instrValid   (instrValid),
        .instr        (instr),
        .rsValue      (rsValue),
        .imm          (imm),
        .nop          (nop),
        .pcStall      (pcStall),
        .branchBubble (branchBubble)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    // ======================================================================
    // reference model
    // ======================================================================

    function automatic logic writesDest(input hazardPkg::opcodeT opc);
        return (opc[4:3] == 2'b00) || (opc[4:2] == 3'b010) ||
               (opc[4:2] == 3'b110) || (opc == hazardPkg::OPC_LOAD);
    endfunction

    function automatic logic isMemOp(input hazardPkg::opcodeT opc);
        return (opc == hazardPkg::OPC_LOAD) || (opc == hazardPkg::OPC_STORE);
    endfunction

    // returns {nop, pcStall, branchBubble} for the offered slot.
    function automatic logic [2:0] expectOutputs(
        input hazardPkg::instrT                             word,
        input hazardPkg::addrT                              rsv,
        input hazardPkg::addrT                              immv,
        input logic                                         valid,
        input hazardPkg::regIdxT [hazardPkg::NUM_STAGES-1:0] rdH,
        input logic [hazardPkg::NUM_STAGES-1:0]             rdV,
        input hazardPkg::addrT [hazardPkg::NUM_STAGES-1:0]   addrH,
        input logic [hazardPkg::NUM_STAGES-1:0]             addrV
    );
        hazardPkg::opcodeT opc;
        hazardPkg::addrT   effAddr;
        logic              ctrlOp;
        logic              regConflict;
        logic              memConflict;
        logic              stall;

        opc = word[15:11];
        effAddr = rsv + immv;
        ctrlOp = (opc[4:2] == 3'b011) || (opc[4:2] == 3'b111);
        regConflict = 1'b0;
        memConflict = 1'b0;
        for (int i = 0; i < hazardPkg::NUM_STAGES; i++) begin
            if (rdV[i] && ((rdH[i] == word[10:8]) || (rdH[i] == word[7:5]))) begin
                regConflict = 1'b1;
            end
            if (isMemOp(opc) && addrV[i] && (addrH[i] == effAddr)) begin
                memConflict = 1'b1;
            end
        end
        stall = valid && (regConflict || memConflict);
        return {stall, stall, valid && !stall && ctrlOp};
    endfunction

    // the inputs stay put until 1 ns after the next edge, so the state the
    // DUT loads on that edge can be formed here already.
    task automatic advanceModel(input logic issued);
        hazardPkg::addrT effAddr;

        effAddr = rsValue + imm;
        rdModel = {rdModel[hazardPkg::NUM_STAGES-2:0], instr[4:2]};
        rdValidModel = {rdValidModel[hazardPkg::NUM_STAGES-2:0],
                        issued && writesDest(instr[15:11])};
        addrModel = {addrModel[hazardPkg::NUM_STAGES-2:0], effAddr};
        addrValidModel = {addrValidModel[hazardPkg::NUM_STAGES-2:0],
                          issued && isMemOp(instr[15:11])};
    endtask

    // ======================================================================
    // checks
    // ======================================================================

    task automatic checkFlag(input logic got, input logic exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkInstr(input hazardPkg::instrT got, input hazardPkg::instrT exp,
                              input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    always @(negedge clk) begin
        logic [2:0] expected;

        if (!rstN) begin
            rdValidModel = '0;
            addrValidModel = '0;
            stallSeen = 1'b0;
        end else begin
            expected = expectOutputs(instr, rsValue, imm, instrValid, rdModel,
                                     rdValidModel, addrModel, addrValidModel);
            checkFlag(nop, expected[2], "nop");
            checkFlag(pcStall, expected[1], "pcStall");
            checkFlag(branchBubble, expected[0], "branchBubble");
            if (stallSeen && instrValid) begin
                checkInstr(instr, heldInstr, "held instr");
            end
            stallSeen = expected[1];
            heldInstr = instr;
            advanceModel(instrValid && !expected[1]);
        end
    end

    // ======================================================================
    // stimulus
    // ======================================================================

    function automatic hazardPkg::instrT buildInstr(
        input hazardPkg::opcodeT opc,
        input hazardPkg::regIdxT rsIdx,
        input hazardPkg::regIdxT rtIdx,
        input hazardPkg::regIdxT rdIdx
    );
        return {opc, rsIdx, rtIdx, rdIdx, 2'b00};
    endfunction

    task automatic idleCycles(input int count);
        instrValid = 1'b0;
        instr = '0;
        repeat (count) begin
            @(posedge clk);
            #1;
        end
    endtask

    // holds the slot while pcStall is high and returns the stall length and
    // the branchBubble level of the cycle in which it issued.
    task automatic offerInstr(
        input  hazardPkg::instrT word,
        input  hazardPkg::addrT  rsv,
        input  hazardPkg::addrT  immv,
        output int               stalls,
        output logic             bubble
    );
        logic issued;

        instrValid = 1'b1;
        instr = word;
        rsValue = rsv;
        imm = immv;
        stalls = 0;
        issued = 1'b0;
        while (!issued) begin
            @(negedge clk);
            if (pcStall !== 1'b1) begin
                issued = 1'b1;
            end else if (stalls >= STALL_TIMEOUT) begin
                $display("timeout: the stall did not clear within %0d cycles", STALL_TIMEOUT);
                $display("Done: errors found");
                $finish;
            end else begin
                stalls++;
            end
        end
        bubble = branchBubble;
        @(posedge clk);
        #1;
    endtask

    task automatic waitResetRelease();
        int waited;

        waited = 0;
        while (rstN !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rstN !== 1'b1) begin
            $display("timeout: reset was never released");
            $display("Done: errors found");
            $finish;
        end
    endtask

    task automatic finishTest(input string name);
        if (errorCount == testStartErrors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d error(s)", name, errorCount - testStartErrors);
        end
        testStartErrors = errorCount;
    endtask

    initial begin
        int                stalls;
        int                totalStalls;
        logic              bubble;
        hazardPkg::opcodeT opc;

        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        rsValue = '0;
        imm = '0;
        totalStalls = 0;
        void'($urandom(32'h9dcf));
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
        waitResetRelease();
        #1;

        idleCycles(8);
        finishTest("1 idle after reset");

        // a writer of r3 followed at once by readers in rs and then in rt.
        offerInstr(buildInstr(OPC_ALU, 1, 2, 3), 16'h0, 16'h0, stalls, bubble);
        checkFlag(stalls == 0, 1'b1, "writer issued without stall");
        offerInstr(buildInstr(OPC_ALU, 3, 4, 5), 16'h0, 16'h0, stalls, bubble);
        checkFlag(stalls == 4, 1'b1, "rs reader stalled four cycles");
        idleCycles(4);
        offerInstr(buildInstr(OPC_ALU, 1, 2, 3), 16'h0, 16'h0, stalls, bubble);
        offerInstr(buildInstr(OPC_ALU, 6, 3, 7), 16'h0, 16'h0, stalls, bubble);
        checkFlag(stalls == 4, 1'b1, "rt reader stalled four cycles");
        idleCycles(4);
        // an empty slot in between already counts as one of the four.
        offerInstr(buildInstr(OPC_ALU, 1, 2, 3), 16'h0, 16'h0, stalls, bubble);
        idleCycles(1);
        offerInstr(buildInstr(OPC_ALU, 3, 4, 5), 16'h0, 16'h0, stalls, bubble);
        checkFlag(stalls == 3, 1'b1, "reader after a bubble stalled three cycles");
        idleCycles(4);
        finishTest("2 register hazards");

        offerInstr(buildInstr(hazardPkg::OPC_STORE, 1, 2, 0), 16'h0100, 16'h0020,
                   stalls, bubble);
        offerInstr(buildInstr(hazardPkg::OPC_LOAD, 4, 5, 6), 16'h0110, 16'h0010,
                   stalls, bubble);
        checkFlag(stalls == 4, 1'b1, "load to the stored address stalled");
        idleCycles(4);
        offerInstr(buildInstr(hazardPkg::OPC_STORE, 1, 2, 0), 16'h0200, 16'h0000,
                   stalls, bubble);
        offerInstr(buildInstr(hazardPkg::OPC_LOAD, 4, 5, 6), 16'h0200, 16'h0004,
                   stalls, bubble);
        checkFlag(stalls == 0, 1'b1, "load to another address issued");
        idleCycles(4);
        offerInstr(buildInstr(hazardPkg::OPC_STORE, 1, 2, 3), 16'h0300, 16'h0000,
                   stalls, bubble);
        offerInstr(buildInstr(OPC_ALU, 3, 3, 7), 16'h0, 16'h0, stalls, bubble);
        checkFlag(stalls == 0, 1'b1, "store left no register hazard");
        idleCycles(4);
        finishTest("3 memory hazards");

        offerInstr(buildInstr(OPC_BRANCH, 1, 2, 0), 16'h0, 16'h0, stalls, bubble);
        checkFlag(bubble, 1'b1, "branch raised branchBubble");
        offerInstr(buildInstr(OPC_JUMP, 1, 2, 0), 16'h0, 16'h0, stalls, bubble);
        checkFlag(bubble, 1'b1, "jump raised branchBubble");
        offerInstr(buildInstr(OPC_ALU, 0, 0, 3), 16'h0, 16'h0, stalls, bubble);
        checkFlag(bubble, 1'b0, "ALU left branchBubble low");
        offerInstr(buildInstr(OPC_BRANCH, 3, 1, 0), 16'h0, 16'h0, stalls, bubble);
        checkFlag(stalls == 4, 1'b1, "branch reading r3 stalled");
        checkFlag(bubble, 1'b1, "stalled branch raised branchBubble on issue");
        idleCycles(4);
        finishTest("4 branch and jump");

        // one slot in four is a load or store, so address conflicts are common.
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            if ($urandom_range(4) == 0) begin
                idleCycles(1);
            end
            if ($urandom_range(3) == 0) begin
                opc = ($urandom_range(1) == 0) ? hazardPkg::OPC_LOAD : hazardPkg::OPC_STORE;
            end else begin
                opc = hazardPkg::opcodeT'($urandom_range(31));
            end
            offerInstr(buildInstr(opc, hazardPkg::regIdxT'($urandom_range(3)),
                                  hazardPkg::regIdxT'($urandom_range(3)),
                                  hazardPkg::regIdxT'($urandom_range(3))),
                       hazardPkg::addrT'($urandom_range(3)),
                       hazardPkg::addrT'($urandom_range(3)), stalls, bubble);
            totalStalls += stalls;
        end
        idleCycles(4);
        $display("random stream: %0d instructions, %0d stall cycles", RANDOM_COUNT,
                 totalStalls);
        finishTest("5 random stream");

        errorCount += hazardDetect_inst.hazardDetectProps_inst.failCount;
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
